// File: verilog/riscv_pkg.sv
`default_nettype none

package riscv_pkg;

  // default widths of the execute stage.
  localparam int DEF_DATA_WIDTH = 32;
  localparam int DEF_INST_WIDTH = 32;

  // plain vector types.
  typedef logic [DEF_INST_WIDTH-1:0] inst_t;
  typedef logic [DEF_DATA_WIDTH-1:0] data_t;
  typedef logic [6:0]                opcode_t;   // inst[6:0].
  typedef logic [2:0]                funct3_t;   // inst[14:12].
  typedef logic [3:0]                funcode_t;  // {alt, funct3} or a fixed code.
  typedef logic [4:0]                shamt_t;    // rv32 shift amount.

  // major opcodes of rv32i.
  localparam opcode_t LUI    = 7'b0110111;
  localparam opcode_t AUIPC  = 7'b0010111;
  localparam opcode_t JAL    = 7'b1101111;
  localparam opcode_t JALR   = 7'b1100111;
  localparam opcode_t BRANCH = 7'b1100011;
  localparam opcode_t LOAD   = 7'b0000011;
  localparam opcode_t STORE  = 7'b0100011;
  localparam opcode_t OP_IMM = 7'b0010011;
  localparam opcode_t OP     = 7'b0110011;
  localparam opcode_t FENCE  = 7'b0001111;
  localparam opcode_t SYS    = 7'b1110011;

  // funct3 of the shift-right group, where bit 30 picks the arithmetic form.
  localparam funct3_t F3_SR = 3'b101;

  // alu function codes.
  localparam funcode_t FN_ADD  = 4'b0000;
  localparam funcode_t FN_SLL  = 4'b0001;
  localparam funcode_t FN_SLT  = 4'b0010;
  localparam funcode_t FN_SLTU = 4'b0011;
  localparam funcode_t FN_XOR  = 4'b0100;
  localparam funcode_t FN_SRL  = 4'b0101;
  localparam funcode_t FN_OR   = 4'b0110;
  localparam funcode_t FN_AND  = 4'b0111;
  localparam funcode_t FN_SUB  = 4'b1000;
  localparam funcode_t FN_SRA  = 4'b1101;
  localparam funcode_t FN_NONE = 4'b1111;  // opcode without an alu result.

  // from decode: instruction word and the two operands.
  typedef struct packed {
    inst_t inst;
    data_t a;
    data_t b;  // immediate already placed here for the imm forms.
  } ex_in_t;

  // to memory stage.
  typedef struct packed {
    data_t result;
    logic  zero;
  } ex_out_t;

endpackage

`default_nettype wire

// File: verilog/riscv_mux.sv
`timescale 1ns/1ns
`default_nettype none

module riscv_mux #(
  parameter int NR_KEY   = 2,
  parameter int KEY_LEN  = 1,
  parameter int DATA_LEN = 1
) (
  input  logic [KEY_LEN-1:0]                   key,
  input  logic [DATA_LEN-1:0]                  default_out,
  input  logic [NR_KEY*(KEY_LEN+DATA_LEN)-1:0] lut,
  output logic [DATA_LEN-1:0]                  out
);

  localparam int PAIR_LEN = KEY_LEN + DATA_LEN;

  logic [KEY_LEN-1:0]  key_list  [NR_KEY];
  logic [DATA_LEN-1:0] data_list [NR_KEY];

  // pair i sits at lut[i*PAIR_LEN +: PAIR_LEN], key in the upper bits.
  for (genvar i = 0; i < NR_KEY; i++) begin : g_pair
    assign data_list[i] = lut[i*PAIR_LEN +: DATA_LEN];
    assign key_list[i]  = lut[i*PAIR_LEN + DATA_LEN +: KEY_LEN];
  end

  // last matching pair wins.
  always_comb begin
    out = default_out;
    for (int i = 0; i < NR_KEY; i++) begin
      if (key_list[i] == key) begin
        out = data_list[i];
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/riscv_ex_funcode.sv
`timescale 1ns/1ns
`default_nettype none

module riscv_ex_funcode #(
  parameter int INST_WIDTH = riscv_pkg::DEF_INST_WIDTH
) (
  input  riscv_pkg::inst_t    inst,
  output riscv_pkg::funcode_t funcode
);

  import riscv_pkg::*;

  localparam int NR_OPCODE = 11;
  localparam int ALT_BIT   = INST_WIDTH - 2;  // bit 30 of rv32.

  opcode_t  opcode;
  funct3_t  funct3;
  logic     alt;
  funcode_t reg_fn;
  funcode_t imm_fn;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign alt    = inst[ALT_BIT];

  assign reg_fn = {alt, funct3};
  // imm forms only honour bit 30 for srli/srai.
  assign imm_fn = (funct3 == F3_SR) ? {alt, funct3} : {1'b0, funct3};

  riscv_mux #(
    .NR_KEY   (NR_OPCODE),
    .KEY_LEN  ($bits(opcode_t)),
    .DATA_LEN ($bits(funcode_t))
  ) u_fn_mux (
    .key         (opcode),
    .default_out (FN_NONE),
    .lut         ({LUI,    FN_NONE,
                   AUIPC,  FN_NONE,
                   JAL,    FN_NONE,
                   JALR,   FN_NONE,
                   BRANCH, FN_SUB,   // compare by subtraction.
                   LOAD,   FN_NONE,
                   STORE,  FN_NONE,
                   OP_IMM, imm_fn,
                   OP,     reg_fn,
                   FENCE,  FN_NONE,
                   SYS,    FN_NONE}),
    .out         (funcode)
  );

endmodule

`default_nettype wire

// File: verilog/riscv_ex_alu.sv
`timescale 1ns/1ns
`default_nettype none

module riscv_ex_alu #(
  parameter int DATA_WIDTH = riscv_pkg::DEF_DATA_WIDTH
) (
  input  riscv_pkg::funcode_t funcode,
  input  riscv_pkg::data_t    a,
  input  riscv_pkg::data_t    b,
  output riscv_pkg::ex_out_t  res
);

  import riscv_pkg::*;

  localparam int NR_FN = 11;

  shamt_t                shamt;
  logic                  lt_signed;
  logic                  lt_unsigned;

  logic [DATA_WIDTH-1:0] add_res;
  logic [DATA_WIDTH-1:0] sub_res;
  logic [DATA_WIDTH-1:0] sll_res;
  logic [DATA_WIDTH-1:0] srl_res;
  logic [DATA_WIDTH-1:0] sra_res;
  logic [DATA_WIDTH-1:0] slt_res;
  logic [DATA_WIDTH-1:0] sltu_res;
  logic [DATA_WIDTH-1:0] xor_res;
  logic [DATA_WIDTH-1:0] or_res;
  logic [DATA_WIDTH-1:0] and_res;
  logic [DATA_WIDTH-1:0] alu_out;

  assign shamt = b[4:0];  // low five bits only.

  // adder and subtractor, both wrap.
  assign add_res = a + b;
  assign sub_res = a - b;

  // shifter.
  assign sll_res = a << shamt;
  assign srl_res = a >> shamt;
  assign sra_res = $signed(a) >>> shamt;

  // comparators.
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;
  assign slt_res     = {{(DATA_WIDTH-1){1'b0}}, lt_signed};
  assign sltu_res    = {{(DATA_WIDTH-1){1'b0}}, lt_unsigned};

  // logic unit.
  assign xor_res = a ^ b;
  assign or_res  = a | b;
  assign and_res = a & b;

  riscv_mux #(
    .NR_KEY   (NR_FN),
    .KEY_LEN  ($bits(funcode_t)),
    .DATA_LEN (DATA_WIDTH)
  ) u_res_mux (
    .key         (funcode),
    .default_out ({DATA_WIDTH{1'b0}}),
    .lut         ({FN_ADD,  add_res,
                   FN_SLL,  sll_res,
                   FN_SLT,  slt_res,
                   FN_SLTU, sltu_res,
                   FN_XOR,  xor_res,
                   FN_SRL,  srl_res,
                   FN_OR,   or_res,
                   FN_AND,  and_res,
                   FN_SUB,  sub_res,
                   FN_SRA,  sra_res,
                   FN_NONE, {DATA_WIDTH{1'b0}}}),
    .out         (alu_out)
  );

  assign res.result = alu_out;
  assign res.zero   = (alu_out == '0);  // branch equality test.

endmodule

`default_nettype wire

// File: verilog/riscv_ex_stage.sv
`timescale 1ns/1ns
`default_nettype none

module riscv_ex_stage #(
  parameter int DATA_WIDTH = riscv_pkg::DEF_DATA_WIDTH,
  parameter int INST_WIDTH = riscv_pkg::DEF_INST_WIDTH
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid,
  input  riscv_pkg::ex_in_t  ex_in,
  output logic               out_valid,
  output riscv_pkg::ex_out_t ex_out
);

  import riscv_pkg::*;

  funcode_t funcode;
  ex_out_t  alu_res;

  // instruction bits to alu function code.
  riscv_ex_funcode #(
    .INST_WIDTH (INST_WIDTH)
  ) u_funcode (
    .inst    (ex_in.inst),
    .funcode (funcode)
  );

  riscv_ex_alu #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_alu (
    .funcode (funcode),
    .a       (ex_in.a),
    .b       (ex_in.b),
    .res     (alu_res)
  );

  // strobe follows the input by one cycle.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  // result register holds its value when nothing is accepted.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_out <= '0;
    end else if (in_valid) begin
      ex_out <= alu_res;
    end
  end

endmodule

`default_nettype wire

// File: sim/riscv_ex_chk.sv
`timescale 1ns/1ns
`default_nettype none

module riscv_ex_chk (
  input logic               clk,
  input logic               rst_n,
  input logic               in_valid,
  input logic               out_valid,
  input riscv_pkg::ex_out_t ex_out
);

  // strobe is the input strobe delayed by one cycle.
  assert property (@(posedge clk) disable iff (!rst_n)
    $past(rst_n) |-> (out_valid == $past(in_valid)))
    else $error("out_valid does not follow in_valid by one cycle");

  // zero flag tracks the registered result.
  assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> (ex_out.zero == (ex_out.result == '0)))
    else $error("zero flag does not match the result");

  // reset clears the strobe.
  assert property (@(posedge clk)
    !rst_n |=> !out_valid)
    else $error("out_valid high in the cycle after reset");

endmodule

bind riscv_ex_stage riscv_ex_chk u_chk (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_valid  (in_valid),
  .out_valid (out_valid),
  .ex_out    (ex_out)
);

`default_nettype wire

// File: sim/riscv_ex_tb.sv
`timescale 1ns/1ns
`default_nettype none

module riscv_ex_tb;

  import riscv_pkg::*;

  localparam int          DATA_WIDTH = DEF_DATA_WIDTH;
  localparam int          INST_WIDTH = DEF_INST_WIDTH;
  localparam int          TIMEOUT    = 20;     // cycles.
  localparam int          NR_STREAM  = 60;
  localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  ex_in_t      ex_in;
  logic        out_valid;
  ex_out_t     ex_out;
  logic [31:0] lfsr_state;

  riscv_ex_stage #(
    .DATA_WIDTH (DATA_WIDTH),
    .INST_WIDTH (INST_WIDTH)
  ) UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .ex_in     (ex_in),
    .out_valid (out_valid),
    .ex_out    (ex_out)
  );

  always #2 clk = ~clk;

  // one lfsr step per bit taken, msb first.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        lsb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lsb        = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (lsb) begin
        lfsr_state = lfsr_state ^ LFSR_TAPS;
      end
      val = {val[30:0], lsb};
    end
    return val;
  endfunction

  // rd x3, rs1 x1, rs2 x2.
  function automatic inst_t make_inst(input opcode_t op, input logic [2:0] f3, input logic alt);
    return {1'b0, alt, 5'd0, 5'd2, 5'd1, f3, 5'd3, op};
  endfunction

  function automatic ex_out_t model(input inst_t inst, input data_t a, input data_t b);
    funcode_t fn;
    ex_out_t  exp;
    case (inst[6:0])
      OP:      fn = {inst[30], inst[14:12]};
      OP_IMM:  fn = (inst[14:12] == 3'b101) ? {inst[30], 3'b101} : {1'b0, inst[14:12]};
      BRANCH:  fn = FN_SUB;
      default: fn = FN_NONE;
    endcase
    case (fn)
      FN_ADD:  exp.result = a + b;
      FN_SUB:  exp.result = a - b;
      FN_SLL:  exp.result = a << b[4:0];
      FN_SRL:  exp.result = a >> b[4:0];
      FN_SRA:  exp.result = $signed(a) >>> b[4:0];
      FN_SLT:  exp.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      FN_SLTU: exp.result = (a < b) ? 32'd1 : 32'd0;
      FN_XOR:  exp.result = a ^ b;
      FN_OR:   exp.result = a | b;
      FN_AND:  exp.result = a & b;
      default: exp.result = '0;
    endcase
    exp.zero = (exp.result == '0);
    return exp;
  endfunction

  task automatic check(input data_t actual, input data_t expected, input string what);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, what, actual, expected);
      $display("sim failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic send(input inst_t inst, input data_t a, input data_t b);
    @(posedge clk);
    in_valid <= 1'b1;
    ex_in    <= {inst, a, b};
  endtask

  task automatic idle();
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  // outputs are sampled on the falling edge.
  task automatic expect_out(input ex_out_t exp, input int max_wait, input string what);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!out_valid) begin
      waited++;
      if (waited >= max_wait) begin
        $display("timeout: out_valid did not rise within %0d cycles for %s", max_wait, what);
        $display("sim failed");
        $fatal(1, "timeout");
      end
      @(negedge clk);
    end
    check(ex_out.result, exp.result, {what, " result"});
    check(32'(ex_out.zero), 32'(exp.zero), {what, " zero"});
  endtask

  task automatic run_one(input inst_t inst, input data_t a, input data_t b, input string what);
    send(inst, a, b);
    idle();
    expect_out(model(inst, a, b), TIMEOUT, what);
  endtask

  task automatic first_strobe_latency();
    @(negedge clk);
    check(32'(out_valid), 32'd0, "out_valid after reset");
    check(ex_out.result, 32'd0, "result after reset");
    send(make_inst(OP, 3'b000, 1'b0), 32'd20, 32'd22);
    @(negedge clk);
    check(32'(out_valid), 32'd0, "out_valid before latency");
    idle();
    @(negedge clk);
    check(32'(out_valid), 32'd1, "out_valid after one cycle");
    check(ex_out.result, 32'd42, "first result");
  endtask

  task automatic sweep_alu_ops(input opcode_t op);
    data_t a_list [4];
    data_t b_list [4];
    logic  alt;
    a_list = '{32'hffff_fff6, 32'h8000_0001, 32'h0000_0005, 32'h1234_5678};
    b_list = '{32'h0000_0005, 32'hffff_ffff, 32'hffff_fff6, 32'h1234_5678};
    for (int f = 0; f < 16; f++) begin
      alt = f[3];
      // bit 30 only matters for add/sub and the right shifts.
      if (!alt || f[2:0] == 3'b101 || (op == OP && f[2:0] == 3'b000)) begin
        for (int k = 0; k < 4; k++) begin
          run_one(make_inst(op, f[2:0], alt), a_list[k], b_list[k], "alu op");
        end
      end
    end
  endtask

  task automatic addi_ignores_bit30();
    run_one(make_inst(OP_IMM, 3'b000, 1'b1), 32'd10, 32'd3, "addi with bit 30");
    check(ex_out.result, 32'd13, "addi with bit 30 adds");
  endtask

  task automatic branch_compare();
    run_one(make_inst(BRANCH, 3'b000, 1'b0), 32'd42, 32'd42, "branch equal");
    check(32'(ex_out.zero), 32'd1, "branch equal zero");
    run_one(make_inst(BRANCH, 3'b001, 1'b0), 32'd42, 32'd40, "branch unequal");
    check(32'(ex_out.zero), 32'd0, "branch unequal zero");
  endtask

  task automatic non_alu_opcodes();
    opcode_t ops [9];
    ops = '{LUI, AUIPC, JAL, JALR, LOAD, STORE, FENCE, SYS, 7'b1111111};
    for (int k = 0; k < 9; k++) begin
      send(make_inst(ops[k], 3'b000, 1'b1), 32'hdead_beef, 32'h0000_0123);
      idle();
      expect_out({32'd0, 1'b1}, TIMEOUT, "non-alu opcode");
    end
  endtask

  task automatic random_stream();
    inst_t insts [NR_STREAM];
    data_t as [NR_STREAM];
    data_t bs [NR_STREAM];
    for (int i = 0; i < NR_STREAM; i++) begin
      insts[i]      = rand_bits(32);
      insts[i][6:0] = (rand_bits(1) != 0) ? OP : OP_IMM;
      as[i]         = rand_bits(32);
      bs[i]         = rand_bits(32);
    end
    fork
      begin
        for (int i = 0; i < NR_STREAM; i++) begin
          send(insts[i], as[i], bs[i]);
        end
        idle();
      end
      begin
        // after the first result every cycle must carry one.
        for (int i = 0; i < NR_STREAM; i++) begin
          expect_out(model(insts[i], as[i], bs[i]), (i == 0) ? TIMEOUT : 1, "stream");
        end
      end
    join
  endtask

  task automatic strobe_gap();
    send(make_inst(OP, 3'b000, 1'b0), 32'd1, 32'd2);
    @(posedge clk);
    in_valid <= 1'b0;
    ex_in    <= {make_inst(OP, 3'b100, 1'b0), 32'h0000_00f0, 32'h0000_00ff};  // new operands, no strobe.
    @(negedge clk);
    check(32'(out_valid), 32'd1, "out_valid before gap");
    check(ex_out.result, 32'd3, "result before gap");
    send(make_inst(OP, 3'b100, 1'b0), 32'h0000_00f0, 32'h0000_00ff);
    @(negedge clk);
    check(32'(out_valid), 32'd0, "out_valid in gap");
    check(ex_out.result, 32'd3, "result held in gap");
    idle();
    @(negedge clk);
    check(32'(out_valid), 32'd1, "out_valid after gap");
    check(ex_out.result, 32'h0000_000f, "result after gap");
    @(negedge clk);
    check(32'(out_valid), 32'd0, "out_valid after last item");
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    ex_in      = '0;
    lfsr_state = 32'd72;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    first_strobe_latency();
    sweep_alu_ops(OP);
    sweep_alu_ops(OP_IMM);
    addi_ignores_bit30();
    branch_compare();
    non_alu_opcodes();
    random_stream();
    strobe_gap();
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
verilog/riscv_pkg.sv
verilog/riscv_mux.sv
verilog/riscv_ex_funcode.sv
verilog/riscv_ex_alu.sv
verilog/riscv_ex_stage.sv
sim/riscv_ex_chk.sv
sim/riscv_ex_tb.sv

// File: Makefile
# Verilator flow for the execute stage.

VERILATOR ?= verilator
FILELIST  ?= vlog.f
TOP       ?= riscv_ex_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= sim passed

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) --binary -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# exit status comes from the search for the pass line.
sim: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
